// ==== rtl/fx2_pkg.sv ====
`default_nettype none

package fx2_pkg;

	// FIFO addresses as seen on fifoadr
	localparam logic [1:0] ep_out_cmd   = 2'd0; // EP2
	localparam logic [1:0] ep_in_sample = 2'd2; // EP6
	localparam logic [1:0] ep_in_reply  = 2'd3; // EP8

	localparam logic [7:0] op_ping     = 8'h01;
	localparam logic [7:0] op_read_reg = 8'h02;
	localparam logic [7:0] ping_tag    = 8'hA5;

	// Word indices, byte address is index*4
	localparam logic [7:0] reg_id           = 8'd0;
	localparam logic [7:0] reg_ctrl         = 8'd1;
	localparam logic [7:0] reg_cmd_count    = 8'd2;
	localparam logic [7:0] reg_bad_count    = 8'd3;
	localparam logic [7:0] reg_sample_count = 8'd4;

	localparam logic [31:0] bridge_id = 32'hF2B0_0001;

	typedef struct packed {
		logic       valid;
		logic [7:0] opcode;
		logic [7:0] arg;
	} cmd_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} reply_byte_t;

	typedef struct packed {
		logic       enable;
		logic [7:0] divider;
	} ctrl_cfg_t;

	typedef struct packed {
		logic cmd_ok;
		logic cmd_bad;
		logic sample_sent;
	} stats_evt_t;

	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/fx2_fifo_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_fifo_arbiter (
	input  logic                 fifo_clk,
	input  logic                 reset,
	inout  wire  [7:0]           fd,
	input  logic [2:0]           flags,
	output logic                 slrd,
	output logic                 slwr,
	output logic                 sloe,
	output logic                 pktend,
	output logic [1:0]           fifoadr,
	output logic                 wu2,
	output logic [7:0]           cmd_byte,
	output logic                 cmd_wr,
	input  logic [7:0]           sample,
	input  logic                 sample_rdy,
	output logic                 sample_ack,
	input  fx2_pkg::reply_byte_t reply,
	input  logic                 reply_rdy,
	output logic                 reply_ack
);
	typedef enum logic [2:0] {
		st_idle,
		st_cmd_oe,
		st_cmd_read,
		st_reply,
		st_pktend,
		st_turn1,
		st_turn2,
		st_sample
	} state_t;

	state_t state;
	state_t state_next;
	logic cmd_empty;
	logic sample_full;
	logic reply_full;
	logic go_cmd;
	logic go_reply;
	logic write_en;
	logic [7:0] dout;

	// Flags are active low
	assign cmd_empty = ~flags[0];
	assign sample_full = ~flags[1];
	assign reply_full = ~flags[2];

	assign go_cmd = ~cmd_empty;
	assign go_reply = reply_rdy & ~reply_full;

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (go_cmd)
					state_next = st_cmd_oe;
				else if (go_reply)
					state_next = st_reply;
				else if (sample_rdy && !sample_full)
					state_next = st_sample;
			st_cmd_oe:   state_next = st_cmd_read; // Give the FX2 a cycle to drive fd
			st_cmd_read:
				if (cmd_empty)
					state_next = st_idle;
			st_reply:
				if (reply_ack && reply.last)
					state_next = st_pktend;
			st_pktend:   state_next = st_turn1;
			st_turn1:    state_next = st_turn2;
			st_turn2:    state_next = st_sample;
			st_sample:
				if (go_cmd)
					state_next = st_cmd_oe;
				else if (go_reply)
					state_next = st_reply;
				else if (sample_full)
					state_next = st_idle;
			default:     state_next = st_idle;
		endcase
	end

	always_comb
	begin
		case (state)
			st_cmd_oe, st_cmd_read: fifoadr = fx2_pkg::ep_out_cmd;
			st_reply, st_pktend:    fifoadr = fx2_pkg::ep_in_reply;
			default:                fifoadr = fx2_pkg::ep_in_sample;
		endcase
	end

	assign cmd_wr = (state == st_cmd_read) && !cmd_empty;
	assign cmd_byte = cmd_wr ? fd : 8'h00;

	// A sample only goes out while nothing with higher priority is waiting
	assign sample_ack = (state == st_sample) && sample_rdy && !sample_full && !go_cmd && !go_reply;
	assign reply_ack = (state == st_reply) && go_reply;

	assign write_en = sample_ack | reply_ack;
	assign dout = (state == st_reply) ? reply.data : sample;
	assign fd = write_en ? dout : 8'hzz;

	assign slrd = ~cmd_wr;
	assign slwr = ~write_en;
	assign sloe = ~((state == st_cmd_oe) || (state == st_cmd_read));
	assign pktend = ~(state == st_pktend);
	assign wu2 = 1'b1;

endmodule

`default_nettype wire

// ==== rtl/fx2_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_cmd_decoder (
	input  logic                fifo_clk,
	input  logic                reset,
	input  logic [7:0]          cmd_byte,
	input  logic                cmd_wr,
	output fx2_pkg::cmd_t       cmd,
	output fx2_pkg::stats_evt_t evt
);
	logic have_opcode;
	logic [7:0] opcode;
	logic known;
	logic pair_done;
	logic cmd_valid;
	logic cmd_bad;
	logic [7:0] cmd_opcode;
	logic [7:0] cmd_arg;

	assign known = (opcode == fx2_pkg::op_ping) || (opcode == fx2_pkg::op_read_reg);
	assign pair_done = cmd_wr && have_opcode; // Second byte of the pair

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
		begin
			have_opcode <= 1'b0;
			cmd_valid <= 1'b0;
			cmd_bad <= 1'b0;
		end
		else
		begin
			if (cmd_wr)
				have_opcode <= !have_opcode;
			cmd_valid <= pair_done && known;
			cmd_bad <= pair_done && !known;
		end
	end

	always_ff @(posedge fifo_clk)
	begin
		if (cmd_wr && !have_opcode)
			opcode <= cmd_byte;
		if (pair_done)
		begin
			cmd_opcode <= opcode;
			cmd_arg <= cmd_byte;
		end
	end

	assign cmd = '{valid: cmd_valid, opcode: cmd_opcode, arg: cmd_arg};
	assign evt = '{cmd_ok: cmd_valid, cmd_bad: cmd_bad, sample_sent: 1'b0}; // Samples merged at top

endmodule

`default_nettype wire

// ==== rtl/fx2_reply_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_reply_builder (
	input  logic                 fifo_clk,
	input  logic                 reset,
	input  fx2_pkg::cmd_t        cmd,
	output fx2_pkg::reply_byte_t reply,
	output logic                 reply_rdy,
	input  logic                 reply_ack,
	output logic [7:0]           reg_index,
	input  logic [31:0]          reg_value
);
	logic [31:0] shreg;
	logic [2:0] remaining;
	logic accept;
	logic is_read;

	// Commands that arrive during a reply are dropped
	assign accept = cmd.valid && (remaining == 3'd0);
	assign is_read = (cmd.opcode == fx2_pkg::op_read_reg);
	assign reg_index = cmd.arg;

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
			remaining <= 3'd0;
		else if (accept)
			remaining <= is_read ? 3'd4 : 3'd2;
		else if (reply_ack && remaining != 3'd0)
			remaining <= remaining - 3'd1;
	end

	always_ff @(posedge fifo_clk)
	begin
		if (accept)
		begin
			if (is_read)
				shreg <= reg_value; // Snapshot at accept time
			else
				shreg <= {16'h0000, cmd.arg, fx2_pkg::ping_tag};
		end
		else if (reply_ack)
			shreg <= {8'h00, shreg[31:8]}; // Low byte goes first
	end

	assign reply_rdy = (remaining != 3'd0);
	assign reply = '{data: shreg[7:0], last: remaining == 3'd1};

endmodule

`default_nettype wire

// ==== rtl/fx2_sample_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_sample_source (
	input  logic               fifo_clk,
	input  logic               reset,
	input  fx2_pkg::ctrl_cfg_t cfg,
	output logic [7:0]         sample,
	output logic               sample_rdy,
	input  logic               sample_ack,
	output logic               sample_sent
);
	logic [7:0] count;
	logic [7:0] div_cnt;
	logic rdy;
	logic ack;

	assign ack = sample_ack && rdy;

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
		begin
			count <= 8'd0;
			div_cnt <= 8'd0;
			rdy <= 1'b0;
		end
		else if (ack)
		begin
			count <= count + 8'd1;
			rdy <= cfg.enable && (cfg.divider == 8'd0); // Back to back when undivided
			div_cnt <= (cfg.divider == 8'd0) ? 8'd0 : cfg.divider - 8'd1;
		end
		else if (!rdy && cfg.enable)
		begin
			if (div_cnt == 8'd0)
				rdy <= 1'b1;
			else
				div_cnt <= div_cnt - 8'd1;
		end
	end

	// A byte that is already offered stays until it is taken
	assign sample = count;
	assign sample_rdy = rdy;
	assign sample_sent = ack;

endmodule

`default_nettype wire

// ==== rtl/fx2_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_config_regs (
	input  logic                fifo_clk,
	input  logic                reset,
	input  fx2_pkg::axil_req_t  axil_req,
	output fx2_pkg::axil_rsp_t  axil_rsp,
	input  fx2_pkg::stats_evt_t evt,
	output fx2_pkg::ctrl_cfg_t  cfg,
	input  logic [7:0]          reg_index,
	output logic [31:0]         reg_value
);
	logic wr_ready;
	logic bvalid;
	logic rd_ready;
	logic rvalid;
	logic [31:0] rdata;
	logic [7:0] wr_index;
	logic [7:0] rd_index;
	logic sample_en;
	logic [7:0] sample_div;
	logic [31:0] cmd_count;
	logic [31:0] bad_count;
	logic [31:0] sample_count;

	function automatic logic [31:0] sat_inc(input logic [31:0] value, input logic hit);
		sat_inc = (hit && value != 32'hFFFF_FFFF) ? value + 32'd1 : value;
	endfunction

	function automatic logic [31:0] read_reg(input logic [7:0] index);
		case (index)
			fx2_pkg::reg_id:           read_reg = fx2_pkg::bridge_id;
			fx2_pkg::reg_ctrl:         read_reg = {16'h0000, sample_div, 7'h00, sample_en};
			fx2_pkg::reg_cmd_count:    read_reg = cmd_count;
			fx2_pkg::reg_bad_count:    read_reg = bad_count;
			fx2_pkg::reg_sample_count: read_reg = sample_count;
			default:                   read_reg = 32'h0000_0000;
		endcase
	endfunction

	assign wr_index = {2'b00, axil_req.awaddr[7:2]};
	assign rd_index = {2'b00, axil_req.araddr[7:2]};

	// Write channel, AW and W are taken together
	always_ff @(posedge fifo_clk)
	begin
		if (reset)
		begin
			wr_ready <= 1'b0;
			bvalid <= 1'b0;
			sample_en <= 1'b0;
			sample_div <= 8'd0;
		end
		else
		begin
			wr_ready <= axil_req.awvalid && axil_req.wvalid && !wr_ready && !bvalid;
			if (wr_ready)
			begin
				bvalid <= 1'b1;
				if (wr_index == fx2_pkg::reg_ctrl)
				begin
					if (axil_req.wstrb[0])
						sample_en <= axil_req.wdata[0];
					if (axil_req.wstrb[1])
						sample_div <= axil_req.wdata[15:8];
				end
			end
			else if (bvalid && axil_req.bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
		begin
			rd_ready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			rd_ready <= axil_req.arvalid && !rd_ready && !rvalid;
			if (rd_ready)
				rvalid <= 1'b1;
			else if (rvalid && axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge fifo_clk)
	begin
		if (rd_ready)
			rdata <= read_reg(rd_index);
	end

	always_ff @(posedge fifo_clk)
	begin
		if (reset)
		begin
			cmd_count <= 32'd0;
			bad_count <= 32'd0;
			sample_count <= 32'd0;
		end
		else
		begin
			cmd_count <= sat_inc(cmd_count, evt.cmd_ok);
			bad_count <= sat_inc(bad_count, evt.cmd_bad);
			sample_count <= sat_inc(sample_count, evt.sample_sent);
		end
	end

	always_comb
	begin
		reg_value = read_reg(reg_index); // Same-cycle port for the reply builder
	end

	assign cfg = '{enable: sample_en, divider: sample_div};

	assign axil_rsp = '{
		awready: wr_ready,
		wready:  wr_ready,
		bresp:   2'b00,
		bvalid:  bvalid,
		arready: rd_ready,
		rdata:   rdata,
		rresp:   2'b00,
		rvalid:  rvalid
	};

endmodule

`default_nettype wire

// ==== rtl/fx2_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_bridge (
	input  logic               fifo_clk,
	input  logic               reset,
	inout  wire  [7:0]         fd,
	input  logic [2:0]         flags,
	output logic               slrd,
	output logic               slwr,
	output logic               sloe,
	output logic               pktend,
	output logic [1:0]         fifoadr,
	output logic               wu2,
	input  fx2_pkg::axil_req_t axil_req,
	output fx2_pkg::axil_rsp_t axil_rsp
);
	logic [7:0] cmd_byte;
	logic cmd_wr;
	fx2_pkg::cmd_t cmd;
	fx2_pkg::stats_evt_t dec_evt;
	fx2_pkg::stats_evt_t evt;
	fx2_pkg::reply_byte_t reply;
	logic reply_rdy;
	logic reply_ack;
	logic [7:0] sample;
	logic sample_rdy;
	logic sample_ack;
	logic sample_sent;
	fx2_pkg::ctrl_cfg_t cfg;
	logic [7:0] reg_index;
	logic [31:0] reg_value;

	fx2_fifo_arbiter fx2_fifo_arbiter_inst (
		.fifo_clk   (fifo_clk),
		.reset      (reset),
		.fd         (fd),
		.flags      (flags),
		.slrd       (slrd),
		.slwr       (slwr),
		.sloe       (sloe),
		.pktend     (pktend),
		.fifoadr    (fifoadr),
		.wu2        (wu2),
		.cmd_byte   (cmd_byte),
		.cmd_wr     (cmd_wr),
		.sample     (sample),
		.sample_rdy (sample_rdy),
		.sample_ack (sample_ack),
		.reply      (reply),
		.reply_rdy  (reply_rdy),
		.reply_ack  (reply_ack)
	);

	fx2_cmd_decoder fx2_cmd_decoder_inst (
		.fifo_clk (fifo_clk),
		.reset    (reset),
		.cmd_byte (cmd_byte),
		.cmd_wr   (cmd_wr),
		.cmd      (cmd),
		.evt      (dec_evt)
	);

	fx2_reply_builder fx2_reply_builder_inst (
		.fifo_clk  (fifo_clk),
		.reset     (reset),
		.cmd       (cmd),
		.reply     (reply),
		.reply_rdy (reply_rdy),
		.reply_ack (reply_ack),
		.reg_index (reg_index),
		.reg_value (reg_value)
	);

	fx2_sample_source fx2_sample_source_inst (
		.fifo_clk    (fifo_clk),
		.reset       (reset),
		.cfg         (cfg),
		.sample      (sample),
		.sample_rdy  (sample_rdy),
		.sample_ack  (sample_ack),
		.sample_sent (sample_sent)
	);

	// Decoder events plus the sample count from the source
	assign evt = '{cmd_ok: dec_evt.cmd_ok, cmd_bad: dec_evt.cmd_bad, sample_sent: sample_sent};

	fx2_config_regs fx2_config_regs_inst (
		.fifo_clk  (fifo_clk),
		.reset     (reset),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.evt       (evt),
		.cfg       (cfg),
		.reg_index (reg_index),
		.reg_value (reg_value)
	);

endmodule

`default_nettype wire

// ==== verification/fx2_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_clock_gen (
	output logic fifo_clk,
	output logic reset
);
	initial
	begin
		fifo_clk = 1'b0;
		forever
			#20 fifo_clk = ~fifo_clk; // 40 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge fifo_clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/fx2_bridge_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_bridge_assertions (
	input logic       fifo_clk,
	input logic       reset,
	input logic       slrd,
	input logic       slwr,
	input logic       sloe,
	input logic       pktend,
	input logic [1:0] fifoadr
);
	// Read and write strobes are exclusive
	rd_wr_exclusive: assert property (@(posedge fifo_clk) disable iff (reset) slrd || slwr)
		else $error("slrd and slwr low together");

	oe_on_ep2: assert property (@(posedge fifo_clk) disable iff (reset)
		sloe || fifoadr == fx2_pkg::ep_out_cmd)
		else $error("sloe low outside EP2");

	pktend_on_ep8: assert property (@(posedge fifo_clk) disable iff (reset)
		pktend || fifoadr == fx2_pkg::ep_in_reply)
		else $error("pktend low outside EP8");

	// Bus contention, both sides driving fd
	no_contention: assert property (@(posedge fifo_clk) disable iff (reset) sloe || slwr)
		else $error("fd driven while sloe is low");

endmodule

bind fx2_fifo_arbiter fx2_bridge_assertions fx2_bridge_assertions_inst (
	.fifo_clk (fifo_clk),
	.reset    (reset),
	.slrd     (slrd),
	.slwr     (slwr),
	.sloe     (sloe),
	.pktend   (pktend),
	.fifoadr  (fifoadr)
);

`default_nettype wire

// ==== verification/fx2_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fx2_bridge_tb;
	logic fifo_clk;
	logic reset;
	wire [7:0] fd;
	logic [2:0] flags;
	logic slrd;
	logic slwr;
	logic sloe;
	logic pktend;
	logic [1:0] fifoadr;
	logic wu2;
	fx2_pkg::axil_req_t axil_req;
	fx2_pkg::axil_rsp_t axil_rsp;

	logic [7:0] fd_drv;
	logic [7:0] ep2[$];
	logic [7:0] ep6[$];
	logic [8:0] ep8[$]; // Bit 8 marks a packet end
	logic [7:0] rx_reply[$];
	int pkt_lens[$];
	int cur_len;
	logic [8:0] ep8_entry;
	logic [7:0] exp_sample;
	int ep6_writes;
	int errors;
	int test_errors;
	int test_count;
	logic [31:0] drain_lfsr;
	logic [31:0] stim_lfsr;

	// Reference register state
	logic m_en;
	logic [7:0] m_div;
	logic [31:0] m_cmd_count;
	logic [31:0] m_bad_count;

	fx2_clock_gen fx2_clock_gen_inst (.fifo_clk(fifo_clk), .reset(reset));

	fx2_bridge fx2_bridge_inst (
		.fifo_clk (fifo_clk),
		.reset    (reset),
		.fd       (fd),
		.flags    (flags),
		.slrd     (slrd),
		.slwr     (slwr),
		.sloe     (sloe),
		.pktend   (pktend),
		.fifoadr  (fifoadr),
		.wu2      (wu2),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	assign fd = !sloe ? fd_drv : 8'hzz; // FX2 drives the bus under output enable

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(inout logic [31:0] s, input int n);
		logic [31:0] r;
		r = 32'd0;
		for (int i = 0; i < n; i++)
		begin
			s = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
			r = {r[30:0], s[0]};
		end
		return r;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok)
		else
		begin
			errors++;
			$display("[FAIL] %0t ns: %s", $time, msg);
		end
	endtask

	task automatic check_wait(input logic ok, input string what);
		assert (ok)
		else
		begin
			errors++;
			$display("Timed out at %0t ns while waiting for %s", $time, what);
		end
	endtask

	function automatic logic [31:0] model_reg(input logic [7:0] index);
		case (index)
			fx2_pkg::reg_id:           return fx2_pkg::bridge_id;
			fx2_pkg::reg_ctrl:         return {16'h0000, m_div, 7'h00, m_en};
			fx2_pkg::reg_cmd_count:    return m_cmd_count;
			fx2_pkg::reg_bad_count:    return m_bad_count;
			fx2_pkg::reg_sample_count: return ep6_writes;
			default:                   return 32'h0000_0000;
		endcase
	endfunction

	// FX2 side, EP2 reads, EP6/EP8 captures and random host draining
	always @(posedge fifo_clk)
	begin
		if (!reset)
			check(wu2 == 1'b1, "wu2 is not held high");
		if (!slrd && ep2.size() != 0)
			void'(ep2.pop_front());
		if (!slwr)
		begin
			if (fifoadr == fx2_pkg::ep_in_sample)
			begin
				check(fd == exp_sample, $sformatf("sample %h, expected %h", fd, exp_sample));
				exp_sample = exp_sample + 8'd1;
				ep6.push_back(fd);
				ep6_writes++;
			end
			else if (fifoadr == fx2_pkg::ep_in_reply)
				ep8.push_back({1'b0, fd});
			else
				check(1'b0, $sformatf("write to FIFO address %0d", fifoadr));
		end
		if (!pktend)
			ep8.push_back(9'h100);
		if (ep6.size() != 0 && rand_bits(drain_lfsr, 2) == 32'd3)
			void'(ep6.pop_front()); // Slow drain so EP6 fills up
		if (ep8.size() != 0 && rand_bits(drain_lfsr, 1) == 32'd1)
		begin
			ep8_entry = ep8.pop_front();
			if (ep8_entry[8])
			begin
				pkt_lens.push_back(cur_len);
				cur_len = 0;
			end
			else
			begin
				rx_reply.push_back(ep8_entry[7:0]);
				cur_len++;
			end
		end
		flags <= {ep8.size() < 16, ep6.size() < 16, ep2.size() != 0};
		fd_drv <= (ep2.size() != 0) ? ep2[0] : 8'h00;
	end

	task automatic axi_write(input logic [7:0] index, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		n = 0;
		@(posedge fifo_clk);
		axil_req.awaddr <= {index[5:0], 2'b00};
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid <= 1'b1;
		axil_req.bready <= 1'b1;
		do
		begin
			@(posedge fifo_clk);
			n++;
		end
		while (!axil_rsp.awready && n < 100);
		check_wait(axil_rsp.awready, "awready");
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		n = 0;
		do
		begin
			@(posedge fifo_clk);
			n++;
		end
		while (!axil_rsp.bvalid && n < 100);
		check_wait(axil_rsp.bvalid, "bvalid");
		check(axil_rsp.bresp == 2'b00, $sformatf("bresp %b, expected OKAY", axil_rsp.bresp));
		axil_req.bready <= 1'b0;
		if (index == fx2_pkg::reg_ctrl)
		begin
			if (strb[0])
				m_en = data[0];
			if (strb[1])
				m_div = data[15:8];
		end
	endtask

	task automatic axi_read(input logic [7:0] index, output logic [31:0] data);
		int n;
		n = 0;
		@(posedge fifo_clk);
		axil_req.araddr <= {index[5:0], 2'b00};
		axil_req.arvalid <= 1'b1;
		axil_req.rready <= 1'b1;
		do
		begin
			@(posedge fifo_clk);
			n++;
		end
		while (!axil_rsp.arready && n < 100);
		check_wait(axil_rsp.arready, "arready");
		axil_req.arvalid <= 1'b0;
		n = 0;
		do
		begin
			@(posedge fifo_clk);
			n++;
		end
		while (!axil_rsp.rvalid && n < 100);
		check_wait(axil_rsp.rvalid, "rvalid");
		check(axil_rsp.rresp == 2'b00, $sformatf("rresp %b, expected OKAY", axil_rsp.rresp));
		data = axil_rsp.rdata;
		axil_req.rready <= 1'b0;
	endtask

	task automatic read_expect(input logic [7:0] index, input logic [31:0] expected);
		logic [31:0] value;
		axi_read(index, value);
		check(value == expected, $sformatf("register %0d is %h, expected %h",
			index, value, expected));
	endtask

	task automatic send_cmd(input logic [7:0] opcode, input logic [7:0] arg);
		@(posedge fifo_clk);
		ep2.push_back(opcode);
		ep2.push_back(arg);
	endtask

	task automatic expect_reply(input logic [31:0] value, input int len);
		int n;
		int got;
		n = 0;
		while (pkt_lens.size() == 0 && n < 1000)
		begin
			@(posedge fifo_clk);
			n++;
		end
		check_wait(pkt_lens.size() != 0, "an EP8 packet");
		if (pkt_lens.size() != 0)
		begin
			got = pkt_lens.pop_front();
			check(got == len, $sformatf("reply length %0d, expected %0d", got, len));
			for (int i = 0; i < got; i++)
				check(rx_reply.pop_front() == value[8*i +: 8],
					$sformatf("reply byte %0d, expected %h", i, value[8*i +: 8]));
		end
	endtask

	// Runs until the sample stream has been silent for a while
	task automatic wait_quiet();
		int quiet;
		int n;
		int last;
		quiet = 0;
		n = 0;
		last = ep6_writes;
		while (quiet < 40 && n < 3000)
		begin
			@(posedge fifo_clk);
			n++;
			quiet = (ep6_writes == last) ? quiet + 1 : 0;
			last = ep6_writes;
		end
		check_wait(quiet >= 40, "the sample stream to stop");
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("%s: %0d failures", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic run_stream(input int samples, input int cmds);
		int start;
		int n;
		logic [7:0] div;
		logic [7:0] arg;
		logic [31:0] value;
		div = rand_bits(stim_lfsr, 3);
		axi_write(fx2_pkg::reg_ctrl, {16'h0, div, 8'h01}, 4'hF);
		start = ep6_writes;
		for (int i = 0; i < cmds; i++)
		begin
			arg = rand_bits(stim_lfsr, 8);
			if (rand_bits(stim_lfsr, 1) == 32'd1)
			begin
				send_cmd(fx2_pkg::op_ping, arg);
				expect_reply({16'h0, arg, fx2_pkg::ping_tag}, 2);
			end
			else
			begin
				arg = rand_bits(stim_lfsr, 2) % 3; // Indices that stay stable while streaming
				value = model_reg(arg);
				send_cmd(fx2_pkg::op_read_reg, arg);
				expect_reply(value, 4);
			end
			m_cmd_count++;
		end
		n = 0;
		while (ep6_writes < start + samples && n < 10000)
		begin
			@(posedge fifo_clk);
			n++;
		end
		check_wait(ep6_writes >= start + samples, "sample bytes");
		axi_write(fx2_pkg::reg_ctrl, 32'h0, 4'hF);
		wait_quiet();
		read_expect(fx2_pkg::reg_sample_count, ep6_writes);
		read_expect(fx2_pkg::reg_cmd_count, m_cmd_count);
	endtask

	initial
	begin
		logic [31:0] data;
		logic [3:0] strb;
		logic [7:0] op;
		logic [7:0] arg;
		flags = 3'b110;
		fd_drv = 8'h00;
		axil_req = '0;
		exp_sample = 8'h00;
		ep6_writes = 0;
		cur_len = 0;
		errors = 0;
		test_errors = 0;
		test_count = 0;
		drain_lfsr = 32'h7a7e;
		stim_lfsr = 32'h7a7e;
		m_en = 1'b0;
		m_div = 8'h00;
		m_cmd_count = 0;
		m_bad_count = 0;
		wait (!reset);
		@(posedge fifo_clk);

		read_expect(fx2_pkg::reg_id, fx2_pkg::bridge_id);
		read_expect(8'd9, model_reg(8'd9)); // Unmapped index reads as zero
		for (int i = 0; i < 6; i++)
		begin
			data = rand_bits(stim_lfsr, 32);
			strb = rand_bits(stim_lfsr, 4);
			axi_write(fx2_pkg::reg_ctrl, data, strb);
			read_expect(fx2_pkg::reg_ctrl, model_reg(fx2_pkg::reg_ctrl));
		end
		axi_write(fx2_pkg::reg_ctrl, 32'h0, 4'hF);
		wait_quiet();
		for (int i = 2; i <= 4; i++)
		begin
			axi_write(i, rand_bits(stim_lfsr, 32), 4'hF);
			read_expect(i, model_reg(i));
		end
		end_test("axi register access");

		for (int i = 0; i < 6; i++)
		begin
			arg = rand_bits(stim_lfsr, 8);
			send_cmd(fx2_pkg::op_ping, arg);
			expect_reply({16'h0, arg, fx2_pkg::ping_tag}, 2);
			m_cmd_count++;
		end
		read_expect(fx2_pkg::reg_cmd_count, m_cmd_count);
		end_test("ping");

		for (int i = 0; i <= 5; i++)
		begin
			arg = (i == 5) ? 8'h07 : i; // Last index is out of range
			data = model_reg(arg);
			send_cmd(fx2_pkg::op_read_reg, arg);
			expect_reply(data, 4);
			m_cmd_count++;
		end
		end_test("read register");

		for (int i = 0; i < 5; i++)
		begin
			do
				op = rand_bits(stim_lfsr, 8);
			while (op == fx2_pkg::op_ping || op == fx2_pkg::op_read_reg);
			send_cmd(op, rand_bits(stim_lfsr, 8));
			m_bad_count++;
		end
		repeat (60) @(posedge fifo_clk);
		check(pkt_lens.size() == 0 && rx_reply.size() == 0 && ep8.size() == 0,
			"EP8 traffic after bad opcodes");
		read_expect(fx2_pkg::reg_bad_count, m_bad_count);
		end_test("bad opcodes");

		run_stream(200, 0);
		end_test("sample stream");
		run_stream(100, 8);
		end_test("mixed traffic");

		$display("%0d tests, %0d failures", test_count, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Budget in cycles per test, summed
	initial
	begin
		int budget;
		budget = 3000 + 3000 + 3000 + 1000 + 15000 + 15000;
		#(budget * 40);
		$display("Watchdog expired, the run did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/fx2_pkg.sv
rtl/fx2_fifo_arbiter.sv
rtl/fx2_cmd_decoder.sv
rtl/fx2_reply_builder.sv
rtl/fx2_sample_source.sv
rtl/fx2_config_regs.sv
rtl/fx2_bridge.sv
verification/fx2_clock_gen.sv
verification/fx2_bridge_assertions.sv
verification/fx2_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: fx2_bridge

sources:
  - rtl/fx2_pkg.sv
  - rtl/fx2_fifo_arbiter.sv
  - rtl/fx2_cmd_decoder.sv
  - rtl/fx2_reply_builder.sv
  - rtl/fx2_sample_source.sv
  - rtl/fx2_config_regs.sv
  - rtl/fx2_bridge.sv
  - target: test
    files:
      - verification/fx2_clock_gen.sv
      - verification/fx2_bridge_assertions.sv
      - verification/fx2_bridge_tb.sv
